// File: files.f
+incdir+rtl
rtl/lsu_types_pkg.sv
rtl/lsu_ops_pkg.sv
rtl/lsu_access_if.sv
rtl/lsu_finish_if.sv
rtl/lsu_decode.sv
rtl/lsu_progress_ctrl.sv
rtl/lsu_result.sv
rtl/lsu_top.sv
tb/lsu_checker.sv
tb/tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lsu_types_pkg.sv
      - rtl/lsu_ops_pkg.sv
      - rtl/lsu_access_if.sv
      - rtl/lsu_finish_if.sv
      - rtl/lsu_decode.sv
      - rtl/lsu_progress_ctrl.sv
      - rtl/lsu_result.sv
      - rtl/lsu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/lsu_checker.sv
      - tb/tb_lsu.sv

// File: tb/tb_lsu.sv
// Load/store sequencer testbench
// Clock, reset, command stimulus, SRAM and I/O responders, run limit
`default_nettype none
`include "lsu_config.svh"

module tb_lsu;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RST_CYCLES = 16;
   localparam int N_CMDS     = 48;
   localparam int MAX_CYCLES = N_CMDS * (`LSU_ACK_LIMIT + 8) + RST_CYCLES;

   logic                 clk, RST_I, cmd_stb;
   lsu_ops_pkg::mem_op_e cmd_op;
   lsu_types_pkg::addr_t cmd_adr, ADR_O;
   lsu_types_pkg::word_t cmd_wdat, DAT_O, DAT_I, done_rdat;
   lsu_types_pkg::sel_t  SEL_O;
   logic                 WE_O, STB_O, sram_stb, ctrlreg_we, ACK_I, sram_ack;
   logic                 done_stb, done_err, busy;
   logic                 hold_sram, hold_io;   // Withhold that region's ack
   int                   s_wait, i_wait, cycles, n_issued, n_err, n_done;
   lsu_types_pkg::word_t mem_model [logic [29:0]];

   lsu_top dut0 (.*);

   lsu_checker chk0 (.*);

   always #20 clk = ~clk;

   // Unwritten words read back a pattern of their full address
   function automatic lsu_types_pkg::word_t fill_word(lsu_types_pkg::addr_t a);
      return {a[31:2], 2'b00} ^ 32'h5a3c_96e1;
   endfunction

   // Ack after 0 to 4 falling edges, drop it one cycle later
   task automatic serve(input logic stb, input logic hold, inout logic ack, inout int wait_c);
      logic [29:0]          k;
      lsu_types_pkg::word_t w;
      k = ADR_O[31:2];
      if (ack) begin
         ack    = 1'b0;
         wait_c = -1;
      end else if (stb && !hold) begin
         if (wait_c < 0)
            wait_c = $urandom % 5;
         if (wait_c == 0) begin
            ack = 1'b1;
            w   = mem_model.exists(k) ? mem_model[k] : fill_word(ADR_O);
            if (WE_O) begin
               for (int b = 0; b < 4; b++)
                  if (SEL_O[b]) w[8*b +: 8] = DAT_O[8*b +: 8];
               mem_model[k] = w;
            end else begin
               DAT_I = w;
            end
         end else begin
            wait_c--;
         end
      end
   endtask

   always @(negedge clk) begin
      serve(sram_stb, hold_sram, sram_ack, s_wait);
      serve(STB_O, hold_io, ACK_I, i_wait);
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
         $display("tests failed");
         $finish;
      end
   end

   // One command, then wait for its done strobe
   task automatic issue(lsu_ops_pkg::mem_op_e op, lsu_types_pkg::addr_t a,
                        lsu_types_pkg::word_t d);
      @(negedge clk);
      cmd_stb  = 1'b1;
      cmd_op   = op;
      cmd_adr  = a;
      cmd_wdat = d;
      @(negedge clk);
      cmd_stb = 1'b0;
      while (!done_stb) @(negedge clk);
      n_issued++;
   endtask

   initial begin
      lsu_types_pkg::addr_t base;
      void'($urandom(32'h7d21));
      clk       = 1'b0;
      RST_I     = 1'b1;
      cmd_stb   = 1'b0;
      cmd_op    = lsu_ops_pkg::OP_LW;
      cmd_adr   = '0;
      cmd_wdat  = '0;
      DAT_I     = '0;
      ACK_I     = 1'b0;
      sram_ack  = 1'b0;
      hold_sram = 1'b0;
      hold_io   = 1'b0;
      s_wait    = -1;
      i_wait    = -1;
      cycles    = 0;
      n_issued  = 0;
      repeat (RST_CYCLES) @(negedge clk);
      RST_I = 1'b0;

      // Stores then loads of every size, two SRAM and two I/O words
      for (int t = 0; t < 4; t++) begin
         base = (t < 2) ? {1'b1, 29'($urandom), 2'b00} : {2'b01, 28'($urandom), 2'b00};
         issue(lsu_ops_pkg::OP_SW, base, $urandom);
         issue(lsu_ops_pkg::OP_SB, base + ($urandom % 4), $urandom);
         issue(lsu_ops_pkg::OP_SH, base + 2 * ($urandom % 2), $urandom);
         issue(lsu_ops_pkg::OP_LB, base + ($urandom % 4), '0);
         issue(lsu_ops_pkg::OP_LBU, base + ($urandom % 4), '0);
         issue(lsu_ops_pkg::OP_LH, base + 2 * ($urandom % 2), '0);
         issue(lsu_ops_pkg::OP_LHU, base + 2 * ($urandom % 2), '0);
         issue(lsu_ops_pkg::OP_LW, base, '0);
      end

      // Misaligned, unmapped and control register loads
      issue(lsu_ops_pkg::OP_SH, 32'h8000_1001, 32'h1234_5678);
      issue(lsu_ops_pkg::OP_LW, 32'h8000_1002, '0);
      issue(lsu_ops_pkg::OP_LH, 32'h4000_0203, '0);
      issue(lsu_ops_pkg::OP_LW, 32'h0000_0100, '0);
      issue(lsu_ops_pkg::OP_SW, 32'h3000_0000, 32'hdead_beef);
      issue(lsu_ops_pkg::OP_LW, 32'h2000_0010, '0);
      issue(lsu_ops_pkg::OP_SW, 32'h2000_0011, 32'h0bad_0bad);

      // Control register writes
      issue(lsu_ops_pkg::OP_SW, 32'h2000_0040, $urandom);
      issue(lsu_ops_pkg::OP_SB, 32'h2000_0045, $urandom);
      issue(lsu_ops_pkg::OP_SH, 32'h2000_004a, $urandom);

      // Ack timeouts, then a clean access
      hold_sram = 1'b1;
      issue(lsu_ops_pkg::OP_LW, 32'h8000_2000, '0);
      hold_sram = 1'b0;
      hold_io   = 1'b1;
      issue(lsu_ops_pkg::OP_SW, 32'h4000_3000, 32'hcafe_f00d);
      hold_io   = 1'b0;
      issue(lsu_ops_pkg::OP_SW, 32'h8000_2000, 32'h89ab_cdef);
      issue(lsu_ops_pkg::OP_LW, 32'h8000_2000, '0);

      // Second command while busy must be dropped
      @(negedge clk);
      cmd_stb  = 1'b1;
      cmd_op   = lsu_ops_pkg::OP_SW;
      cmd_adr  = 32'h8000_2000;
      cmd_wdat = 32'h0102_0304;
      @(negedge clk);
      cmd_adr  = 32'h4000_3000;   // busy is high here
      @(negedge clk);
      cmd_stb = 1'b0;
      while (!done_stb) @(negedge clk);
      n_issued++;
      repeat (6) @(negedge clk);

      if (n_done != n_issued)
         $display("Error: %0d commands issued but %0d completions checked",
                  n_issued, n_done);
      $display("Summary: %0d accesses checked, %0d errors", n_done,
               n_err + ((n_done != n_issued) ? 1 : 0));
      if (n_err == 0 && n_done == n_issued)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/lsu_checker.sv
// Load/store sequencer checker
// Watches the DUT ports, keeps its own memory image and counts errors
`default_nettype none
`include "lsu_config.svh"

module lsu_checker (
   input  logic                  clk,
   input  logic                  RST_I,
   input  logic                  cmd_stb,
   input  lsu_ops_pkg::mem_op_e  cmd_op,
   input  lsu_types_pkg::addr_t  cmd_adr,
   input  lsu_types_pkg::word_t  cmd_wdat,
   input  lsu_types_pkg::addr_t  ADR_O,
   input  lsu_types_pkg::word_t  DAT_O,
   input  lsu_types_pkg::sel_t   SEL_O,
   input  logic                  WE_O,
   input  logic                  STB_O,
   input  logic                  sram_stb,
   input  logic                  ctrlreg_we,
   input  logic                  ACK_I,
   input  logic                  sram_ack,
   input  logic                  done_stb,
   input  lsu_types_pkg::word_t  done_rdat,
   input  logic                  done_err,
   input  logic                  busy,
   output int                    n_err,
   output int                    n_done
);
   timeunit 1ns;
   timeprecision 100ps;

   lsu_types_pkg::word_t mem [logic [29:0]];  // Word image of SRAM and I/O
   lsu_ops_pkg::mem_op_e e_op;
   lsu_types_pkg::addr_t e_adr;
   lsu_types_pkg::word_t e_dat;
   lsu_types_pkg::word_t e_rdat;
   lsu_ops_pkg::region_e e_reg;
   logic                 e_bad, e_wr, e_err;
   logic                 active;               // One access open
   logic                 acked;
   int                   cyc, done_at, stb_n, creg_n, rst_n;

   initial begin
      n_err  = 0;
      n_done = 0;
      active = 1'b0;
      cyc    = 0;
      rst_n  = 0;
   end

   function automatic logic is_write(lsu_ops_pkg::mem_op_e op);
      return op inside {lsu_ops_pkg::OP_SB, lsu_ops_pkg::OP_SH, lsu_ops_pkg::OP_SW};
   endfunction

   function automatic logic [1:0] size_of(lsu_ops_pkg::mem_op_e op);
      case (op)
         lsu_ops_pkg::OP_LB, lsu_ops_pkg::OP_LBU, lsu_ops_pkg::OP_SB: return 2'd0;
         lsu_ops_pkg::OP_LH, lsu_ops_pkg::OP_LHU, lsu_ops_pkg::OP_SH: return 2'd1;
         default: return 2'd2;
      endcase
   endfunction

   // Lane rule: byte by address, half low or high, word all four
   function automatic lsu_types_pkg::sel_t lane_sel(lsu_ops_pkg::mem_op_e op,
                                                    lsu_types_pkg::addr_t a);
      if (size_of(op) == 2'd0)
         return 4'b0001 << a[1:0];
      if (size_of(op) == 2'd1)
         return a[1] ? 4'b1100 : 4'b0011;
      return 4'b1111;
   endfunction

   function automatic lsu_types_pkg::word_t replicate(lsu_ops_pkg::mem_op_e op,
                                                      lsu_types_pkg::word_t d);
      if (size_of(op) == 2'd0)
         return {4{d[7:0]}};
      if (size_of(op) == 2'd1)
         return {2{d[15:0]}};
      return d;
   endfunction

   function automatic lsu_ops_pkg::region_e region_of(lsu_types_pkg::addr_t a);
      if (a[31])
         return lsu_ops_pkg::REG_SRAM;
      if (a[31:30] == `LSU_REGION_IO)
         return lsu_ops_pkg::REG_IO;
      if (a[31:28] == `LSU_REGION_CREG)
         return lsu_ops_pkg::REG_CREG;
      return lsu_ops_pkg::REG_NONE;
   endfunction

   // Misaligned, unmapped, or a read of the write-only control registers
   function automatic logic is_bad(lsu_ops_pkg::mem_op_e op, lsu_types_pkg::addr_t a);
      lsu_ops_pkg::region_e r;
      r = region_of(a);
      if ((size_of(op) == 2'd2 && a[1:0] != 2'b00) || (size_of(op) == 2'd1 && a[0]))
         return 1'b1;
      return (r == lsu_ops_pkg::REG_NONE) || (r == lsu_ops_pkg::REG_CREG && !is_write(op));
   endfunction

   function automatic lsu_types_pkg::word_t extend_load(lsu_ops_pkg::mem_op_e op,
                                                        lsu_types_pkg::addr_t a,
                                                        lsu_types_pkg::word_t w);
      lsu_types_pkg::word_t s;
      s = w >> (8 * a[1:0]);
      case (op)
         lsu_ops_pkg::OP_LB:  return {{24{s[7]}}, s[7:0]};
         lsu_ops_pkg::OP_LBU: return {24'h0, s[7:0]};
         lsu_ops_pkg::OP_LH:  return {{16{s[15]}}, s[15:0]};
         lsu_ops_pkg::OP_LHU: return {16'h0, s[15:0]};
         default:             return w;
      endcase
   endfunction

   task automatic report_fail(string msg);
      n_err++;
      $display("Error at %0t: %s", $time, msg);
   endtask

   task automatic compare(string what, lsu_types_pkg::word_t got, lsu_types_pkg::word_t exp);
      if (got !== exp) begin
         n_err++;
         $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Merge a store, or pick up the expected load, on the ack edge
   task automatic take_ack();
      logic [29:0]          k;
      lsu_types_pkg::word_t w;
      lsu_types_pkg::word_t d;
      lsu_types_pkg::sel_t  s;
      k = e_adr[31:2];
      s = lane_sel(e_op, e_adr);
      d = replicate(e_op, e_dat);
      if (mem.exists(k)) begin
         w = mem[k];
      end else if (e_wr && s == 4'b1111) begin
         w = '0;                      // Whole word store, old contents unused
      end else begin
         report_fail("access to a word never written as a whole");
         return;
      end
      if (e_wr) begin
         for (int b = 0; b < 4; b++)
            if (s[b]) w[8*b +: 8] = d[8*b +: 8];
         mem[k] = w;
      end else begin
         e_rdat = extend_load(e_op, e_adr, w);
      end
   endtask

   always @(posedge clk) begin
      cyc++;
      if (RST_I) begin
         rst_n++;
         // First reset edge only loads the registers
         if (rst_n > 1 && (STB_O || sram_stb || WE_O || ctrlreg_we || SEL_O != '0
                           || done_stb || busy))
            report_fail("an output is not low during reset");
      end else begin
         if (STB_O || sram_stb) begin
            if (!active || e_bad || e_reg == lsu_ops_pkg::REG_CREG || acked) begin
               report_fail("bus strobe high with no bus access waiting");
            end else begin
               if (STB_O != (e_reg == lsu_ops_pkg::REG_IO)
                   || sram_stb != (e_reg == lsu_ops_pkg::REG_SRAM))
                  report_fail("strobe raised for the wrong region");
               compare("ADR_O", ADR_O, e_adr);
               compare("SEL_O", 32'(SEL_O), 32'(lane_sel(e_op, e_adr)));
               compare("WE_O", 32'(WE_O), 32'(e_wr));
               if (e_wr)
                  compare("DAT_O", DAT_O, replicate(e_op, e_dat));
               stb_n++;
               if ((STB_O && ACK_I) || (sram_stb && sram_ack)) begin
                  acked   = 1'b1;
                  done_at = cyc + 2;
                  take_ack();
               end else if (stb_n == `LSU_ACK_LIMIT) begin
                  done_at = cyc + 2;      // Strobe must drop on this edge
               end else if (stb_n > `LSU_ACK_LIMIT) begin
                  report_fail("strobe held past the ack limit");
               end
            end
         end else if (WE_O) begin
            report_fail("WE_O high without a strobe");
         end

         if (ctrlreg_we) begin
            if (!active || e_bad || e_reg != lsu_ops_pkg::REG_CREG) begin
               report_fail("ctrlreg_we with no control register write open");
            end else begin
               creg_n++;
               compare("ADR_O", ADR_O, e_adr);
               compare("DAT_O", DAT_O, replicate(e_op, e_dat));
               compare("SEL_O", 32'(SEL_O), 32'(lane_sel(e_op, e_adr)));
            end
         end

         if (done_stb) begin
            if (!active) begin
               report_fail("done_stb with no access open");
            end else begin
               if (cyc != done_at)
                  report_fail($sformatf("done_stb in cycle %0d, due in cycle %0d",
                                        cyc, done_at));
               e_err = e_bad || (e_reg != lsu_ops_pkg::REG_CREG && !acked);
               compare("done_err", 32'(done_err), 32'(e_err));
               compare("done_rdat", done_rdat, (e_wr || e_err) ? 32'h0 : e_rdat);
               if (e_reg == lsu_ops_pkg::REG_CREG && !e_bad && creg_n != 1)
                  report_fail($sformatf("ctrlreg_we lasted %0d cycles, not one", creg_n));
               active = 1'b0;
               n_done++;
            end
         end

         // New command, judged after this edge's outputs
         if (cmd_stb && !busy) begin
            if (active)
               report_fail("command accepted while an access is open");
            active  = 1'b1;
            e_op    = cmd_op;
            e_adr   = cmd_adr;
            e_dat   = cmd_wdat;
            e_wr    = is_write(cmd_op);
            e_reg   = region_of(cmd_adr);
            e_bad   = is_bad(cmd_op, cmd_adr);
            e_rdat  = '0;
            acked   = 1'b0;
            stb_n   = 0;
            creg_n  = 0;
            done_at = (e_bad || e_reg == lsu_ops_pkg::REG_CREG) ? cyc + 3 : -1;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/lsu_top.sv
// Load/store sequencer top level
// Decode, progress control and result stages behind plain ports
`default_nettype none

module lsu_top (
   input  logic                  clk,
   input  logic                  RST_I,
   input  logic                  cmd_stb,
   input  lsu_ops_pkg::mem_op_e  cmd_op,
   input  lsu_types_pkg::addr_t  cmd_adr,
   input  lsu_types_pkg::word_t  cmd_wdat,
   output lsu_types_pkg::addr_t  ADR_O,
   output lsu_types_pkg::word_t  DAT_O,
   output lsu_types_pkg::sel_t   SEL_O,
   output logic                  WE_O,
   output logic                  STB_O,
   output logic                  sram_stb,
   output logic                  ctrlreg_we,
   input  lsu_types_pkg::word_t  DAT_I,
   input  logic                  ACK_I,
   input  logic                  sram_ack,
   output logic                  done_stb,
   output lsu_types_pkg::word_t  done_rdat,
   output logic                  done_err,
   output logic                  busy
);
   lsu_access_if acc_if ();
   lsu_finish_if fin_if ();

   lsu_decode u_decode (
      .clk      (clk),
      .RST_I    (RST_I),
      .cmd_stb  (cmd_stb),
      .cmd_op   (cmd_op),
      .cmd_adr  (cmd_adr),
      .cmd_wdat (cmd_wdat),
      .busy     (busy),       // Fed back from progress control
      .acc      (acc_if.dec)
   );

   lsu_progress_ctrl u_progress (
      .clk        (clk),
      .RST_I      (RST_I),
      .acc        (acc_if.exe),
      .fin        (fin_if.exe),
      .ACK_I      (ACK_I),
      .sram_ack   (sram_ack),
      .DAT_I      (DAT_I),
      .ADR_O      (ADR_O),
      .DAT_O      (DAT_O),
      .SEL_O      (SEL_O),
      .WE_O       (WE_O),
      .STB_O      (STB_O),
      .sram_stb   (sram_stb),
      .ctrlreg_we (ctrlreg_we),
      .busy       (busy)
   );

   lsu_result u_result (
      .clk       (clk),
      .RST_I     (RST_I),
      .fin       (fin_if.res),
      .done_stb  (done_stb),
      .done_err  (done_err),
      .done_rdat (done_rdat)
   );

endmodule

`default_nettype wire

// File: rtl/lsu_result.sv
// Load result alignment
// Moves the addressed lane down to bit 0, extends by size and sign,
// registers the outcome with a one-cycle done strobe
`default_nettype none

module lsu_result (
   input  logic                  clk,
   input  logic                  RST_I,
   lsu_finish_if.res             fin,
   output logic                  done_stb,
   output logic                  done_err,
   output lsu_types_pkg::word_t  done_rdat
);
   lsu_types_pkg::word_t masked;
   lsu_types_pkg::word_t shifted;
   lsu_types_pkg::word_t ext;

   // Drop lanes outside the access
   assign masked = fin.rdat & {{8{fin.sel[3]}}, {8{fin.sel[2]}},
                               {8{fin.sel[1]}}, {8{fin.sel[0]}}};
   assign shifted = masked >> {fin.adr_lo, 3'b000};

   always_comb begin
      case (fin.size)
         lsu_ops_pkg::SZ_BYTE: ext = {{24{fin.sign & shifted[7]}}, shifted[7:0]};
         lsu_ops_pkg::SZ_HALF: ext = {{16{fin.sign & shifted[15]}}, shifted[15:0]};
         default:              ext = shifted;
      endcase
   end

   always_ff @(posedge clk) begin
      if (RST_I) begin
         done_stb <= 1'b0;
         done_err <= 1'b0;
      end else begin
         done_stb <= fin.fin;
         done_err <= fin.fin & fin.err;
      end
   end

   // Stores and failed accesses return zero
   always_ff @(posedge clk) begin
      if (fin.fin)
         done_rdat <= (fin.write | fin.err) ? '0 : ext;
   end

   a_done_pulse: assert property (@(posedge clk) disable iff (RST_I)
      done_stb |=> !done_stb);

endmodule

`default_nettype wire

// File: rtl/lsu_progress_ctrl.sv
// Bus progress control
// Raises the region strobe, holds it until its own ack or a timeout,
// pulses ctrlreg_we for control register writes and reports the end
`default_nettype none
`include "lsu_config.svh"

module lsu_progress_ctrl (
   input  logic                  clk,
   input  logic                  RST_I,
   lsu_access_if.exe             acc,
   lsu_finish_if.exe             fin,
   input  logic                  ACK_I,
   input  logic                  sram_ack,
   input  lsu_types_pkg::word_t  DAT_I,
   output lsu_types_pkg::addr_t  ADR_O,
   output lsu_types_pkg::word_t  DAT_O,
   output lsu_types_pkg::sel_t   SEL_O,
   output logic                  WE_O,
   output logic                  STB_O,
   output logic                  sram_stb,
   output logic                  ctrlreg_we,
   output logic                  busy
);
   localparam int CNT_W = $clog2(`LSU_ACK_LIMIT + 1);

   lsu_ops_pkg::pctl_state_e state;
   logic [CNT_W-1:0]         wait_cnt;   // Strobe cycles without ack
   logic                     ack_seen;
   logic                     time_out;
   logic                     launch;
   logic                     tail;       // Cycle of done_stb in result

   // Each strobe only listens to its own ack
   assign ack_seen = (STB_O & ACK_I) | (sram_stb & sram_ack);
   assign time_out = (wait_cnt == CNT_W'(`LSU_ACK_LIMIT - 1));
   assign launch   = acc.go & ~acc.bad;

   assign fin.fin = (state == lsu_ops_pkg::PC_FIN);
   assign busy    = acc.go | (state != lsu_ops_pkg::PC_IDLE) | tail;

   always_ff @(posedge clk) begin
      if (RST_I) begin
         state      <= lsu_ops_pkg::PC_IDLE;
         STB_O      <= 1'b0;
         sram_stb   <= 1'b0;
         WE_O       <= 1'b0;
         ctrlreg_we <= 1'b0;
         SEL_O      <= '0;
         wait_cnt   <= '0;
         fin.err    <= 1'b0;
         tail       <= 1'b0;
      end else begin
         ctrlreg_we <= 1'b0;                         // Single cycle pulse
         tail       <= (state == lsu_ops_pkg::PC_FIN);
         case (state)
            lsu_ops_pkg::PC_IDLE: begin
               if (acc.go) begin
                  fin.err  <= acc.bad;
                  wait_cnt <= '0;
                  if (acc.bad) begin
                     state <= lsu_ops_pkg::PC_FIN;   // No strobe at all
                  end else if (acc.region == lsu_ops_pkg::REG_CREG) begin
                     SEL_O      <= acc.sel;
                     ctrlreg_we <= acc.write;        // No bus cycle needed
                     state      <= lsu_ops_pkg::PC_FIN;
                  end else begin
                     SEL_O    <= acc.sel;
                     STB_O    <= (acc.region == lsu_ops_pkg::REG_IO);
                     sram_stb <= (acc.region == lsu_ops_pkg::REG_SRAM);
                     WE_O     <= acc.write;
                     state    <= lsu_ops_pkg::PC_BUS;
                  end
               end
            end
            lsu_ops_pkg::PC_BUS: begin
               if (ack_seen | time_out) begin
                  STB_O    <= 1'b0;
                  sram_stb <= 1'b0;
                  WE_O     <= 1'b0;
                  fin.err  <= ~ack_seen;             // Late ack still wins
                  state    <= lsu_ops_pkg::PC_FIN;
               end else begin
                  wait_cnt <= wait_cnt + 1'b1;
               end
            end
            lsu_ops_pkg::PC_FIN: state <= lsu_ops_pkg::PC_IDLE;
            default:             state <= lsu_ops_pkg::PC_IDLE;
         endcase
      end
   end

   // Bus address and store data
   always_ff @(posedge clk) begin
      if (launch) begin
         ADR_O <= acc.adr;
         DAT_O <= acc.wdat;
      end
   end

   // Access shape, passed on to result alignment
   always_ff @(posedge clk) begin
      if (acc.go) begin
         fin.sel    <= acc.sel;
         fin.size   <= acc.size;
         fin.sign   <= acc.sign;
         fin.adr_lo <= acc.adr[1:0];
         fin.write  <= acc.write;
      end
      if ((state == lsu_ops_pkg::PC_BUS) & ack_seen)
         fin.rdat <= DAT_I;                          // Read data on the ack edge
   end

   a_one_strobe: assert property (@(posedge clk) disable iff (RST_I)
      !(STB_O && sram_stb));

   a_sel_live: assert property (@(posedge clk) disable iff (RST_I)
      (STB_O || sram_stb) |-> (SEL_O != '0));

   // Register writes last exactly one cycle
   a_creg_pulse: assert property (@(posedge clk) disable iff (RST_I)
      ctrlreg_we |=> !ctrlreg_we);

endmodule

`default_nettype wire

// File: rtl/lsu_decode.sv
// Load/store command decode
// Takes a command strobe when idle, classifies region and size,
// flags misaligned or unmapped accesses, builds selects and lane data
`default_nettype none
`include "lsu_config.svh"

module lsu_decode (
   input  logic                  clk,
   input  logic                  RST_I,
   input  logic                  cmd_stb,
   input  lsu_ops_pkg::mem_op_e  cmd_op,
   input  lsu_types_pkg::addr_t  cmd_adr,
   input  lsu_types_pkg::word_t  cmd_wdat,
   input  logic                  busy,
   lsu_access_if.dec             acc
);
   lsu_ops_pkg::size_e   size_c;
   lsu_ops_pkg::region_e region_c;
   lsu_types_pkg::sel_t  sel_c;
   lsu_types_pkg::word_t lane_c;
   logic                 sign_c;
   logic                 write_c;
   logic                 misalign;
   logic                 unmapped;
   logic                 accept;

   assign accept = cmd_stb & ~busy;  // Commands while busy are dropped

   // Opcode to size, sign and direction
   always_comb begin
      size_c  = lsu_ops_pkg::SZ_WORD;
      sign_c  = 1'b0;
      write_c = 1'b0;
      case (cmd_op)
         lsu_ops_pkg::OP_LB:  begin size_c = lsu_ops_pkg::SZ_BYTE; sign_c = 1'b1; end
         lsu_ops_pkg::OP_LBU: size_c = lsu_ops_pkg::SZ_BYTE;
         lsu_ops_pkg::OP_LH:  begin size_c = lsu_ops_pkg::SZ_HALF; sign_c = 1'b1; end
         lsu_ops_pkg::OP_LHU: size_c = lsu_ops_pkg::SZ_HALF;
         lsu_ops_pkg::OP_LW:  size_c = lsu_ops_pkg::SZ_WORD;
         lsu_ops_pkg::OP_SB:  begin size_c = lsu_ops_pkg::SZ_BYTE; write_c = 1'b1; end
         lsu_ops_pkg::OP_SH:  begin size_c = lsu_ops_pkg::SZ_HALF; write_c = 1'b1; end
         lsu_ops_pkg::OP_SW:  begin size_c = lsu_ops_pkg::SZ_WORD; write_c = 1'b1; end
         default: ;
      endcase
   end

   // Region from the top address bits, SRAM wins on bit 31
   always_comb begin
      if (cmd_adr[31])
         region_c = lsu_ops_pkg::REG_SRAM;
      else if (cmd_adr[31:30] == `LSU_REGION_IO)
         region_c = lsu_ops_pkg::REG_IO;
      else if (cmd_adr[31:28] == `LSU_REGION_CREG)
         region_c = lsu_ops_pkg::REG_CREG;
      else
         region_c = lsu_ops_pkg::REG_NONE;
   end

   // SW rule from the core, extended to halfwords
   assign misalign = ((size_c == lsu_ops_pkg::SZ_WORD) & (|cmd_adr[1:0]))
                   | ((size_c == lsu_ops_pkg::SZ_HALF) & cmd_adr[0]);
   // Control registers are write only, so loads there count as unmapped
   assign unmapped = (region_c == lsu_ops_pkg::REG_NONE)
                   | ((region_c == lsu_ops_pkg::REG_CREG) & ~write_c);

   // Byte selects and replicated store lanes
   always_comb begin
      case (size_c)
         lsu_ops_pkg::SZ_BYTE: begin
            sel_c  = 4'b0001 << cmd_adr[1:0];
            lane_c = {4{cmd_wdat[7:0]}};
         end
         lsu_ops_pkg::SZ_HALF: begin
            sel_c  = cmd_adr[1] ? 4'b1100 : 4'b0011;
            lane_c = {2{cmd_wdat[15:0]}};
         end
         default: begin
            sel_c  = 4'b1111;
            lane_c = cmd_wdat;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (RST_I)
         acc.go <= 1'b0;
      else
         acc.go <= accept;
   end

   // Access fields, held until the next accepted command
   always_ff @(posedge clk) begin
      if (accept) begin
         acc.adr    <= cmd_adr;
         acc.wdat   <= lane_c;
         acc.sel    <= sel_c;
         acc.write  <= write_c;
         acc.region <= region_c;
         acc.bad    <= misalign | unmapped;
         acc.size   <= size_c;
         acc.sign   <= sign_c;
      end
   end

endmodule

`default_nettype wire

// File: rtl/lsu_finish_if.sv
// End of an access, handed from progress control to result
// Fields are valid with fin
`default_nettype none

interface lsu_finish_if;
   logic                   fin;     // One-cycle pulse
   logic                   err;
   lsu_types_pkg::word_t   rdat;    // DAT_I taken on the ack cycle
   lsu_types_pkg::sel_t    sel;
   lsu_ops_pkg::size_e     size;
   logic                   sign;
   lsu_types_pkg::lane_t   adr_lo;
   logic                   write;

   modport exe (output fin, err, rdat, sel, size, sign, adr_lo, write);
   modport res (input fin, err, rdat, sel, size, sign, adr_lo, write);
endinterface

`default_nettype wire

// File: rtl/lsu_access_if.sv
// Decoded access, handed from decode to progress control
// Fields are valid in the cycle go is high
`default_nettype none

interface lsu_access_if;
   logic                   go;      // One-cycle pulse
   lsu_types_pkg::addr_t   adr;
   lsu_types_pkg::word_t   wdat;    // Store data, lanes replicated
   lsu_types_pkg::sel_t    sel;
   logic                   write;
   lsu_ops_pkg::region_e   region;
   logic                   bad;     // Misaligned or unmapped
   lsu_ops_pkg::size_e     size;
   logic                   sign;    // Load sign-extends

   modport dec (output go, adr, wdat, sel, write, region, bad, size, sign);
   modport exe (input go, adr, wdat, sel, write, region, bad, size, sign);
endinterface

`default_nettype wire

// File: rtl/lsu_ops_pkg.sv
// Load/store sequencer encodings
// Operations, address regions, access sizes and progress FSM states
`default_nettype none

package lsu_ops_pkg;

   // Command opcodes as seen on cmd_op
   typedef enum logic [2:0] {
      OP_LB  = 3'd0,
      OP_LBU = 3'd1,
      OP_LH  = 3'd2,
      OP_LHU = 3'd3,
      OP_LW  = 3'd4,
      OP_SB  = 3'd5,
      OP_SH  = 3'd6,
      OP_SW  = 3'd7
   } mem_op_e;

   // Region selected by the upper address bits
   typedef enum logic [1:0] {
      REG_SRAM = 2'd0,
      REG_IO   = 2'd1,
      REG_CREG = 2'd2,
      REG_NONE = 2'd3
   } region_e;

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_e;

   // Progress control FSM
   typedef enum logic [1:0] {
      PC_IDLE = 2'd0,
      PC_BUS  = 2'd1,  // Strobe out, waiting for ack
      PC_FIN  = 2'd2   // Access finished, fin high
   } pctl_state_e;

endpackage

`default_nettype wire

// File: rtl/lsu_types_pkg.sv
// Load/store sequencer data types
// Plain vector widths for the bus address, data word and byte selects
`default_nettype none

package lsu_types_pkg;

   // Byte address on the bus
   typedef logic [31:0] addr_t;

   // Data word, four byte lanes
   typedef logic [31:0] word_t;

   // One select bit per byte lane, bit 0 is the low lane
   typedef logic [3:0] sel_t;

   // Two low address bits, lane offset within a word
   typedef logic [1:0] lane_t;

endpackage

`default_nettype wire

// File: rtl/lsu_config.svh
// Load/store sequencer configuration
// Ack timeout limit and the address region codes
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Cycles a strobe may stay high without an ack
`define LSU_ACK_LIMIT 15

// Compared against ADR[31:30]
`define LSU_REGION_IO 2'b01

// Compared against ADR[31:28]
`define LSU_REGION_CREG 4'b0010

`endif
